// ==== compile.f ====
source/tinyrv_pkg.sv
source/fetch_queue.sv
source/decode_issue.sv
source/alu_exec.sv
source/core_top.sv
tests/core_checker.sv
tests/tb_clock.sv
tests/core_tb.sv

// ==== Makefile ====
# Verilator flow for the RV32I subset core back end

VERILATOR  ?= verilator
TOP        ?= core_tb
FILELIST   ?= compile.f
BUILD_DIR  ?= obj_dir
VFLAGS     ?= --timing --assert
SIM_ARGS   ?= +verilator+error+limit+1000
PASS_TEXT  ?= Simulation completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) \
		-f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tests/core_tb.sv ====
// Core back end testbench
// Random RV32I subset stream with gaps, in-order reference model,
// commit-by-commit comparison and a closing report

`timescale 1ns/1ps

module core_tb
  import tinyrv_pkg::*;
;

  localparam int NUM_INSTR = 600;
  localparam int K_ADD   = 0;
  localparam int K_SUB   = 1;
  localparam int K_AND   = 2;
  localparam int K_OR    = 3;
  localparam int K_XOR   = 4;
  localparam int K_ADDI  = 5;
  localparam int K_LUI   = 6;
  localparam int K_AUIPC = 7;

  logic        clk;
  logic        rst;
  logic        in_val = 1'b0;
  logic        in_rdy;
  fetch_pkt_t  in_pkt = '0;
  logic        commit_val;
  commit_pkt_t commit_pkt;

  integer      seed = 32'h7ae7_f858;
  word_t       model_regs [32] = '{default: '0};
  commit_pkt_t expected_q [$];
  word_t       next_pc = 32'h0000_1000;
  seq_t        next_seq = 8'd0;
  int          offer_kind = 0;
  int          gap_left = 0;
  int          accepted = 0;
  int          commits = 0;
  int          errors = 0;
  int          end_errors = 0;
  int          timeouts = 0;

  tb_clock #(.PERIOD_NS(20), .RESET_CYCLES(2)) i_tb_clock (.clk(clk), .rst(rst));

  core_top #(.FQ_DEPTH(4)) i_core_top (
    .clk        (clk),
    .rst        (rst),
    .in_val     (in_val),
    .in_rdy     (in_rdy),
    .in_pkt     (in_pkt),
    .commit_val (commit_val),
    .commit_pkt (commit_pkt)
  );

  // --------------------------------------------------------------------------
  // Encoding and reference model
  // --------------------------------------------------------------------------

  // RV32I field layout, last kind is LW which the core does not support
  function automatic word_t encode(input int kind, input reg_addr_t rd, input reg_addr_t rs1,
                                   input reg_addr_t rs2, input logic [19:0] imm);
    case (kind)
      K_ADD:   return {7'h00, rs2, rs1, 3'b000, rd, 7'b0110011};
      K_SUB:   return {7'h20, rs2, rs1, 3'b000, rd, 7'b0110011};
      K_AND:   return {7'h00, rs2, rs1, 3'b111, rd, 7'b0110011};
      K_OR:    return {7'h00, rs2, rs1, 3'b110, rd, 7'b0110011};
      K_XOR:   return {7'h00, rs2, rs1, 3'b100, rd, 7'b0110011};
      K_ADDI:  return {imm[11:0], rs1, 3'b000, rd, 7'b0010011};
      K_LUI:   return {imm, rd, 7'b0110111};
      K_AUIPC: return {imm, rd, 7'b0010111};
      default: return {imm[11:0], rs1, 3'b010, rd, 7'b0000011};
    endcase
  endfunction

  // Program-order model, runs once per accepted packet
  task automatic model_accept(input int kind, input fetch_pkt_t pkt);
    commit_pkt_t exp;
    word_t       a;
    word_t       b;
    word_t       result;
    a = model_regs[pkt.inst[19:15]];
    b = model_regs[pkt.inst[24:20]];
    case (kind)
      K_ADD:   result = a + b;
      K_SUB:   result = a - b;
      K_AND:   result = a & b;
      K_OR:    result = a | b;
      K_XOR:   result = a ^ b;
      K_ADDI:  result = a + {{20{pkt.inst[31]}}, pkt.inst[31:20]};
      K_LUI:   result = {pkt.inst[31:12], 12'h000};
      K_AUIPC: result = pkt.pc + {pkt.inst[31:12], 12'h000};
      default: result = '0;
    endcase
    exp.waddr = pkt.inst[11:7];
    // x0 and unsupported encodings never write
    exp.wen   = (kind <= K_AUIPC) && (exp.waddr != 5'd0);
    exp.wdata = result;
    exp.seq   = pkt.seq;
    if (exp.wen)
      model_regs[exp.waddr] = result;
    expected_q.push_back(exp);
    accepted++;
  endtask

  // --------------------------------------------------------------------------
  // Commit checking
  // --------------------------------------------------------------------------

  task automatic report_mismatch(input string name, input word_t exp, input word_t act);
    errors++;
    $display("ERR %s expected %h actual %h", name, exp, act);
  endtask

  task automatic check_commit(input commit_pkt_t got);
    commit_pkt_t exp;
    commits++;
    assert (expected_q.size() > 0) else begin
      errors++;
      $display("Commit with seq %0d arrived with nothing outstanding", got.seq);
    end
    if (expected_q.size() > 0) begin
      exp = expected_q.pop_front();
      assert (got.seq == exp.seq)
        else report_mismatch("commit_seq", 32'(exp.seq), 32'(got.seq));
      assert (got.wen == exp.wen)
        else report_mismatch("commit_wen", 32'(exp.wen), 32'(got.wen));
      // Address and data only matter for real writes
      if (exp.wen) begin
        assert (got.waddr == exp.waddr)
          else report_mismatch("commit_waddr", 32'(exp.waddr), 32'(got.waddr));
        assert (got.wdata == exp.wdata)
          else report_mismatch("commit_wdata", exp.wdata, got.wdata);
      end
    end
  endtask

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------

  // New packet or an idle cycle, registers x0 to x7 for frequent hazards
  task automatic offer_next();
    logic [31:0] r;
    logic [31:0] f;
    r = $random(seed);
    f = $random(seed);
    if (accepted >= NUM_INSTR) begin
      in_val <= 1'b0;
    end else if (gap_left > 0) begin
      gap_left--;
      in_val <= 1'b0;
    end else begin
      offer_kind = int'(r[31:8] % 24'd9);
      in_pkt.inst <= encode(offer_kind, {2'b00, f[2:0]}, {2'b00, f[5:3]},
                            {2'b00, f[8:6]}, f[28:9]);
      in_pkt.pc   <= next_pc;
      in_pkt.seq  <= next_seq;
      in_val      <= 1'b1;
      if (r[2:0] == 3'd0)
        gap_left = int'(r[5:3]);
    end
  endtask

  always @(posedge clk) begin
    if (rst) begin
      in_val <= 1'b0;
    end else begin
      if (commit_val)
        check_commit(commit_pkt);
      if (in_val && in_rdy) begin
        model_accept(offer_kind, in_pkt);
        next_pc  = next_pc + 32'd4;
        next_seq = next_seq + 8'd1;
      end
      // Held until accepted
      if (!in_val || in_rdy)
        offer_next();
    end
  end

  // --------------------------------------------------------------------------
  // Run control
  // --------------------------------------------------------------------------

  task automatic wait_reset_release(output bit ok);
    int cycles;
    cycles = 0;
    while (rst && cycles < 20) begin
      @(negedge clk);
      cycles++;
    end
    ok = !rst;
    if (!ok)
      $display("Timeout: reset was never released");
  endtask

  task automatic wait_all_accepted(output bit ok);
    int cycles;
    cycles = 0;
    while (accepted < NUM_INSTR && cycles < NUM_INSTR * 20) begin
      @(negedge clk);
      cycles++;
    end
    ok = (accepted >= NUM_INSTR);
    if (!ok)
      $display("Timeout: only %0d of %0d packets were accepted", accepted, NUM_INSTR);
  endtask

  task automatic wait_drained(output bit ok);
    int cycles;
    cycles = 0;
    while (expected_q.size() > 0 && cycles < 200) begin
      @(negedge clk);
      cycles++;
    end
    ok = (expected_q.size() == 0);
    if (!ok)
      $display("Timeout: %0d instructions never committed", expected_q.size());
  endtask

  initial begin
    bit ok;
    wait_reset_release(ok);
    if (ok)
      wait_all_accepted(ok);
    if (ok)
      wait_drained(ok);
    if (!ok)
      timeouts++;
    assert (commits == accepted) else begin
      end_errors++;
      $display("Commit count %0d does not match accepted count %0d", commits, accepted);
    end
    $display("Errors: %0d, timeouts: %0d, accepted: %0d, committed: %0d",
             errors + end_errors, timeouts, accepted, commits);
    if (errors == 0 && end_errors == 0 && timeouts == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// ==== tests/tb_clock.sv ====
// Testbench clock and reset
// Free-running clock, reset high for the first few rising edges

`timescale 1ns/1ps

module tb_clock #(
  parameter int PERIOD_NS    = 20,
  parameter int RESET_CYCLES = 2
) (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (RESET_CYCLES) @(posedge clk);
    rst <= 1'b0;
  end

endmodule

// ==== tests/core_checker.sv ====
// Decode-issue checker
// Concurrent assertions on hazard stalls, decode register readiness
// and reset behavior, bound into every decode_issue instance

`timescale 1ns/1ps

module core_checker
  import tinyrv_pkg::*;
(
  input logic        clk,
  input logic        rst,
  input logic        dec_val,
  input logic        q_val,
  input logic        issue_val,
  input issue_pkt_t  issue_pkt,
  input logic        commit_val,
  input logic        use_rs1,
  input logic        use_rs2,
  input logic        dec_wen,
  input reg_addr_t   rs1,
  input reg_addr_t   rs2,
  input reg_addr_t   rd
);

  // --------------------------------------------------------------------------
  // Writers still in the ALU
  // --------------------------------------------------------------------------

  // Issued one and two cycles ago, not yet written back
  logic      w1_val;
  logic      w2_val;
  reg_addr_t w1_addr;
  reg_addr_t w2_addr;
  logic      rs1_hit;
  logic      rs2_hit;
  logic      rd_hit;

  always_ff @(posedge clk) begin
    if (rst) begin
      w1_val <= 1'b0;
      w2_val <= 1'b0;
    end else begin
      w1_val <= issue_val && issue_pkt.wen;
      w2_val <= w1_val;
    end
  end

  always_ff @(posedge clk) begin
    w1_addr <= issue_pkt.waddr;
    w2_addr <= w1_addr;
  end

  assign rs1_hit = (w1_val && w1_addr == rs1) || (w2_val && w2_addr == rs1);
  assign rs2_hit = (w1_val && w1_addr == rs2) || (w2_val && w2_addr == rs2);
  assign rd_hit  = (w1_val && w1_addr == rd) || (w2_val && w2_addr == rd);

  // --------------------------------------------------------------------------
  // Assertions
  // --------------------------------------------------------------------------

  // RAW, no issue over a source still in flight
  a_no_raw_issue: assert property (@(posedge clk) disable iff (rst)
    issue_val |-> !(use_rs1 && rs1_hit) && !(use_rs2 && rs2_hit))
  else $error("Issue while a source register is still pending");

  // WAW, only for instructions that write
  a_no_waw_issue: assert property (@(posedge clk) disable iff (rst)
    issue_val |-> !(dec_wen && rd_hit))
  else $error("Issue while the destination register is still pending");

  // Empty decode register takes the queue head at the next edge
  a_empty_ready: assert property (@(posedge clk) disable iff (rst)
    !dec_val && q_val |=> dec_val)
  else $error("Decode register empty but did not take the queue head");

  a_reset_quiet: assert property (@(posedge clk)
    rst |=> !issue_val && !commit_val)
  else $error("Issue or commit strobe high right after reset");

endmodule

bind decode_issue core_checker i_core_checker (
  .clk        (clk),
  .rst        (rst),
  .dec_val    (dec_val),
  .q_val      (q_val),
  .issue_val  (issue_val),
  .issue_pkt  (issue_pkt),
  .commit_val (commit_val),
  .use_rs1    (use_rs1),
  .use_rs2    (use_rs2),
  .dec_wen    (dec_wen),
  .rs1        (rs1),
  .rs2        (rs2),
  .rd         (rd)
);

// ==== source/core_top.sv ====
// Core back end top level
// Fetch queue feeding decode-issue, which feeds the two-stage ALU.
// Commits go back to the register file and out of the core.

`timescale 1ns/1ps

module core_top
  import tinyrv_pkg::*;
#(
  parameter int FQ_DEPTH = 4
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        in_val,
  output logic        in_rdy,
  input  fetch_pkt_t  in_pkt,
  output logic        commit_val,
  output commit_pkt_t commit_pkt
);

  // Queue to decode
  logic       q_val;
  logic       q_rdy;
  fetch_pkt_t q_pkt;

  // Decode to ALU
  logic       issue_val;
  issue_pkt_t issue_pkt;

  fetch_queue #(
    .FQ_DEPTH (FQ_DEPTH)
  ) i_fetch_queue (
    .clk     (clk),
    .rst     (rst),
    .in_val  (in_val),
    .in_rdy  (in_rdy),
    .in_pkt  (in_pkt),
    .out_val (q_val),
    .out_rdy (q_rdy),
    .out_pkt (q_pkt)
  );

  decode_issue i_decode_issue (
    .clk        (clk),
    .rst        (rst),
    .q_val      (q_val),
    .q_rdy      (q_rdy),
    .q_pkt      (q_pkt),
    .issue_val  (issue_val),
    .issue_pkt  (issue_pkt),
    .commit_val (commit_val),
    .commit_pkt (commit_pkt)
  );

  alu_exec i_alu_exec (
    .clk        (clk),
    .rst        (rst),
    .issue_val  (issue_val),
    .issue_pkt  (issue_pkt),
    .commit_val (commit_val),
    .commit_pkt (commit_pkt)
  );

endmodule

// ==== source/alu_exec.sv ====
// ALU execute pipeline
// Two stages: stage 1 holds the issued micro-op and computes,
// stage 2 registers the result as a commit packet.

`timescale 1ns/1ps

module alu_exec
  import tinyrv_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        issue_val,
  input  issue_pkt_t  issue_pkt,
  output logic        commit_val,
  output commit_pkt_t commit_pkt
);

  logic       s1_val;
  issue_pkt_t s1_pkt;
  word_t      s1_result;

  // --------------------------------------------------------------------------
  // Stage 1
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst)
      s1_val <= 1'b0;
    else
      s1_val <= issue_val;
  end

  always_ff @(posedge clk) begin
    if (issue_val)
      s1_pkt <= issue_pkt;
  end

  always_comb begin
    case (s1_pkt.uop)
      UOP_ADD:      s1_result = s1_pkt.op1 + s1_pkt.op2;
      UOP_SUB:      s1_result = s1_pkt.op1 - s1_pkt.op2;
      UOP_AND:      s1_result = s1_pkt.op1 & s1_pkt.op2;
      UOP_OR:       s1_result = s1_pkt.op1 | s1_pkt.op2;
      UOP_XOR:      s1_result = s1_pkt.op1 ^ s1_pkt.op2;
      UOP_PASS_OP2: s1_result = s1_pkt.op2;
      UOP_ADD_PC:   s1_result = s1_pkt.pc + s1_pkt.op2;
      // NOP commits with wen low, data is don't-care
      default:      s1_result = '0;
    endcase
  end

  // --------------------------------------------------------------------------
  // Stage 2, commit
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (rst)
      commit_val <= 1'b0;
    else
      commit_val <= s1_val;
  end

  always_ff @(posedge clk) begin
    if (s1_val) begin
      commit_pkt.waddr <= s1_pkt.waddr;
      commit_pkt.wen   <= s1_pkt.wen;
      commit_pkt.wdata <= s1_result;
      commit_pkt.seq   <= s1_pkt.seq;
    end
  end

endmodule

// ==== source/decode_issue.sv ====
// Decode and issue stage
// Holds one instruction, decodes it, reads the pending-bit register
// file and issues to the ALU once no RAW or WAW hazard remains.

`timescale 1ns/1ps

module decode_issue
  import tinyrv_pkg::*;
(
  input  logic        clk,
  input  logic        rst,
  input  logic        q_val,
  output logic        q_rdy,
  input  fetch_pkt_t  q_pkt,
  output logic        issue_val,
  output issue_pkt_t  issue_pkt,
  input  logic        commit_val,
  input  commit_pkt_t commit_pkt
);

  // --------------------------------------------------------------------------
  // Decode register
  // --------------------------------------------------------------------------

  logic       dec_val;
  fetch_pkt_t dec_pkt;
  logic       q_xfer;

  assign q_xfer = q_val && q_rdy;
  // Free when empty or when the held instruction leaves now
  assign q_rdy  = !dec_val || issue_val;

  always_ff @(posedge clk) begin
    if (rst)
      dec_val <= 1'b0;
    else if (q_xfer)
      dec_val <= 1'b1;
    else if (issue_val)
      dec_val <= 1'b0;
  end

  always_ff @(posedge clk) begin
    if (q_xfer)
      dec_pkt <= q_pkt;
  end

  // --------------------------------------------------------------------------
  // Decoder and immediate generator
  // --------------------------------------------------------------------------

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rs1;
  reg_addr_t  rs2;
  reg_addr_t  rd;
  uop_e       uop;
  logic       legal;
  logic       use_rs1;
  logic       use_rs2;
  logic       op2_imm;
  logic       imm_u;
  logic       dec_wen;
  word_t      imm;

  assign opcode = dec_pkt.inst[6:0];
  assign rd     = dec_pkt.inst[11:7];
  assign funct3 = dec_pkt.inst[14:12];
  assign rs1    = dec_pkt.inst[19:15];
  assign rs2    = dec_pkt.inst[24:20];
  assign funct7 = dec_pkt.inst[31:25];

  always_comb begin
    uop     = UOP_NOP;
    legal   = 1'b0;
    use_rs1 = 1'b0;
    use_rs2 = 1'b0;
    op2_imm = 1'b0;
    imm_u   = 1'b0;
    case (opcode)
      OP_REG: begin
        if (funct7 == F7_BASE) begin
          legal = 1'b1;
          case (funct3)
            F3_ADD_SUB: uop = UOP_ADD;
            F3_XOR:     uop = UOP_XOR;
            F3_OR:      uop = UOP_OR;
            F3_AND:     uop = UOP_AND;
            default:    legal = 1'b0;
          endcase
        end else if (funct7 == F7_SUB && funct3 == F3_ADD_SUB) begin
          legal = 1'b1;
          uop   = UOP_SUB;
        end
        use_rs1 = legal;
        use_rs2 = legal;
      end
      // ADDI only, other I-type ALU ops fall to NOP
      OP_IMM: begin
        if (funct3 == F3_ADD_SUB) begin
          legal   = 1'b1;
          uop     = UOP_ADD;
          use_rs1 = 1'b1;
          op2_imm = 1'b1;
        end
      end
      OP_LUI: begin
        legal   = 1'b1;
        uop     = UOP_PASS_OP2;
        op2_imm = 1'b1;
        imm_u   = 1'b1;
      end
      OP_AUIPC: begin
        legal   = 1'b1;
        uop     = UOP_ADD_PC;
        op2_imm = 1'b1;
        imm_u   = 1'b1;
      end
      default: ;
    endcase
  end

  // x0 writes dropped here
  assign dec_wen = legal && (rd != '0);

  // U-type or sign-extended I-type
  assign imm = imm_u ? {dec_pkt.inst[31:12], 12'b0}
                     : {{20{dec_pkt.inst[31]}}, dec_pkt.inst[31:20]};

  // --------------------------------------------------------------------------
  // Register file with pending bits
  // --------------------------------------------------------------------------

  word_t       regs [32];
  logic [31:0] pend;
  logic [31:0] pend_next;
  logic        rs1_busy;
  logic        rs2_busy;
  logic        rd_busy;

  always_comb begin
    pend_next = pend;
    if (commit_val && commit_pkt.wen)
      pend_next[commit_pkt.waddr] = 1'b0;
    // Set after clear so a same-cycle set wins
    if (issue_val && dec_wen)
      pend_next[rd] = 1'b1;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      regs <= '{default: '0};
      pend <= '0;
    end else begin
      if (commit_val && commit_pkt.wen)
        regs[commit_pkt.waddr] <= commit_pkt.wdata;
      pend <= pend_next;
    end
  end

  // Hazards, WAW only matters when this one writes
  assign rs1_busy = use_rs1 && pend[rs1];
  assign rs2_busy = use_rs2 && pend[rs2];
  assign rd_busy  = dec_wen && pend[rd];

  // --------------------------------------------------------------------------
  // Issue
  // --------------------------------------------------------------------------

  assign issue_val = dec_val && !(rs1_busy || rs2_busy || rd_busy);

  always_comb begin
    issue_pkt.uop   = uop;
    issue_pkt.op1   = use_rs1 ? regs[rs1] : '0;
    issue_pkt.op2   = op2_imm ? imm : regs[rs2];
    issue_pkt.pc    = dec_pkt.pc;
    issue_pkt.waddr = rd;
    issue_pkt.wen   = dec_wen;
    issue_pkt.seq   = dec_pkt.seq;
  end

endmodule

// ==== source/fetch_queue.sv ====
// Fetch queue
// Circular FIFO of fetch packets with valid/ready on both sides.
// Push and pop may happen in the same cycle, also when full.

`timescale 1ns/1ps

module fetch_queue
  import tinyrv_pkg::*;
#(
  parameter int FQ_DEPTH = 4
) (
  input  logic       clk,
  input  logic       rst,
  input  logic       in_val,
  output logic       in_rdy,
  input  fetch_pkt_t in_pkt,
  output logic       out_val,
  input  logic       out_rdy,
  output fetch_pkt_t out_pkt
);

  localparam int AW = $clog2(FQ_DEPTH);

  fetch_pkt_t     mem [FQ_DEPTH];
  logic [AW-1:0]  wr_ptr;
  logic [AW-1:0]  rd_ptr;
  logic [AW:0]    count;
  logic           push;
  logic           pop;

  // Full queue still accepts when the head leaves this cycle
  assign in_rdy  = (count != (AW+1)'(FQ_DEPTH)) || out_rdy;
  assign out_val = (count != '0);
  assign out_pkt = mem[rd_ptr];

  assign push = in_val && in_rdy;
  assign pop  = out_val && out_rdy;

  // Pointers and occupancy
  // Pointers wrap on their own, depth is a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      if (push && !pop)
        count <= count + 1'b1;
      else if (pop && !push)
        count <= count - 1'b1;
    end
  end

  // Storage
  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= in_pkt;
  end

endmodule

// ==== source/tinyrv_pkg.sv ====
// Shared definitions for the RV32I subset core back end.
// Data widths, micro-op encoding, instruction field codes and the
// packet structs passed between fetch, decode-issue and the ALU.

package tinyrv_pkg;

  // --------------------------------------------------------------------------
  // Widths with a meaning
  // --------------------------------------------------------------------------

  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [7:0]  seq_t;

  // Micro-ops understood by the ALU pipeline
  typedef enum logic [2:0] {
    UOP_ADD,
    UOP_SUB,
    UOP_AND,
    UOP_OR,
    UOP_XOR,
    UOP_PASS_OP2,  // LUI
    UOP_ADD_PC,    // AUIPC
    UOP_NOP
  } uop_e;

  // --------------------------------------------------------------------------
  // Opcode and funct codes
  // --------------------------------------------------------------------------

  localparam logic [6:0] OP_REG   = 7'b0110011;
  localparam logic [6:0] OP_IMM   = 7'b0010011;
  localparam logic [6:0] OP_LUI   = 7'b0110111;
  localparam logic [6:0] OP_AUIPC = 7'b0010111;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_SUB  = 7'b0100000;

  // --------------------------------------------------------------------------
  // Packets
  // --------------------------------------------------------------------------

  // Fetch side, also the queue payload
  typedef struct packed {
    word_t inst;
    word_t pc;
    seq_t  seq;
  } fetch_pkt_t;

  // Decode-issue to ALU
  typedef struct packed {
    uop_e      uop;
    word_t     op1;
    word_t     op2;
    word_t     pc;
    reg_addr_t waddr;
    logic      wen;
    seq_t      seq;
  } issue_pkt_t;

  // ALU completion, to regfile and top-level port
  typedef struct packed {
    reg_addr_t waddr;
    logic      wen;
    word_t     wdata;
    seq_t      seq;
  } commit_pkt_t;

endpackage
